//--- logic/rv32i_types.sv
package rv32i_types;

localparam int offset_bits = 5;	// Byte offset within a 32-byte line.
localparam int word_sel_bits = 3;	// Word index within a line.

typedef logic [31:0] addr_t;
typedef logic [31:0] word_t;
typedef logic [255:0] line_t;	// Eight instruction words.

// Default geometry only, eight sets.
typedef logic [31-3-offset_bits:0] tag_t;

typedef enum logic [1:0] {
	idle,
	hit_detection,
	load,
	write_data
} icache_state_t;

endpackage : rv32i_types

//--- logic/icache_control.sv
module icache_control (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic hit,
	input logic lru_out,
	input logic pmem_resp,
	output logic load_pipeline,
	output logic read_data,
	output logic addr_sel,
	output logic load_lru,
	output logic mem_resp,
	output logic pmem_read,
	output logic [1:0] load_data,
	output logic [1:0] load_tag,
	output logic [1:0] set_valid
);

import rv32i_types::*;

icache_state_t state;
icache_state_t next_state;
logic [1:0] victim;

// One-hot victim way for the fill.
assign victim = lru_out ? 2'b10 : 2'b01;

always_ff @(posedge clk) begin
	if (!rst_n)
		state <= idle;
	else
		state <= next_state;
end

always_comb begin
	next_state = state;
	unique case (state)
		idle: begin
			if (mem_read)
				next_state = hit_detection;
		end
		hit_detection: begin
			if (!hit)
				next_state = load;
			else if (!mem_read)
				next_state = idle;	// Stay on a hit with a new request.
		end
		load: begin
			if (pmem_resp)
				next_state = write_data;
		end
		write_data: next_state = hit_detection;
		default: next_state = idle;
	endcase
end

always_comb begin
	load_pipeline = 1'b0;
	read_data = 1'b0;
	addr_sel = 1'b0;
	load_lru = 1'b0;
	mem_resp = 1'b0;
	pmem_read = 1'b0;
	load_data = 2'b00;
	load_tag = 2'b00;
	set_valid = 2'b00;
	unique case (state)
		idle: begin
			load_pipeline = mem_read;
			read_data = mem_read;
		end
		hit_detection: begin
			if (hit) begin
				mem_resp = 1'b1;
				load_lru = 1'b1;
				load_pipeline = mem_read;	// Accept the next request now.
				read_data = mem_read;
			end else begin
				pmem_read = 1'b1;
			end
		end
		load: begin
			if (pmem_resp) begin
				load_data = victim;
				load_tag = victim;
				set_valid = victim;
			end else begin
				pmem_read = 1'b1;
			end
		end
		write_data: begin
			// Re-read the filled line from the held address.
			read_data = 1'b1;
			addr_sel = 1'b1;
		end
		default: begin
			load_pipeline = 1'b0;
		end
	endcase
end

endmodule : icache_control

//--- logic/icache_tag_array.sv
module icache_tag_array #(
	parameter int idx_bits = 3,
	localparam int tag_bits = 32 - idx_bits - rv32i_types::offset_bits
) (
	input logic clk,
	input logic rst_n,
	input logic read_data,
	input logic [idx_bits-1:0] read_index,
	input logic [idx_bits-1:0] write_index,
	input logic [tag_bits-1:0] cmp_tag,
	input logic [1:0] load_tag,
	input logic [1:0] set_valid,
	output logic [1:0] tag_hit,
	output logic hit
);

localparam int num_sets = 2 ** idx_bits;

logic [tag_bits-1:0] tags [2][num_sets];
logic [num_sets-1:0] valid [2];
logic [tag_bits-1:0] tag_q [2];
logic [1:0] valid_q;

// The held tag is also the tag being filled.
always_ff @(posedge clk) begin
	for (int w = 0; w < 2; w++) begin
		if (load_tag[w])
			tags[w][write_index] <= cmp_tag;
		if (read_data)
			tag_q[w] <= tags[w][read_index];
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int w = 0; w < 2; w++)
			valid[w] <= '0;
		valid_q <= 2'b00;
	end else begin
		for (int w = 0; w < 2; w++) begin
			if (set_valid[w])
				valid[w][write_index] <= 1'b1;
			if (read_data)
				valid_q[w] <= valid[w][read_index];	// Registered with the tag.
		end
	end
end

always_comb begin
	for (int w = 0; w < 2; w++)
		tag_hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
end

assign hit = |tag_hit;

endmodule : icache_tag_array

//--- logic/icache_data_array.sv
module icache_data_array #(
	parameter int idx_bits = 3
) (
	input logic clk,
	input logic read_data,
	input logic [idx_bits-1:0] read_index,
	input logic [idx_bits-1:0] write_index,
	input logic [1:0] load_data,
	input rv32i_types::line_t wdata,
	output rv32i_types::line_t way0_line,
	output rv32i_types::line_t way1_line
);

import rv32i_types::*;

localparam int num_sets = 2 ** idx_bits;

line_t lines [2][num_sets];

always_ff @(posedge clk) begin
	for (int w = 0; w < 2; w++) begin
		if (load_data[w])
			lines[w][write_index] <= wdata;	// Whole line from memory.
	end
end

always_ff @(posedge clk) begin
	if (read_data) begin
		way0_line <= lines[0][read_index];
		way1_line <= lines[1][read_index];
	end
end

endmodule : icache_data_array

//--- logic/icache_lru.sv
module icache_lru #(
	parameter int idx_bits = 3
) (
	input logic clk,
	input logic rst_n,
	input logic [idx_bits-1:0] index,
	input logic load_lru,
	input logic [1:0] tag_hit,
	output logic lru_out
);

localparam int num_sets = 2 ** idx_bits;

logic [num_sets-1:0] lru;	// Set bit means way 1 is the victim.

always_ff @(posedge clk) begin
	if (!rst_n)
		lru <= '0;
	else if (load_lru && |tag_hit)
		lru[index] <= tag_hit[0];	// Point away from the hit way.
end

assign lru_out = lru[index];

endmodule : icache_lru

//--- logic/icache_datapath.sv
module icache_datapath #(
	parameter int idx_bits = 3
) (
	input logic clk,
	input logic rst_n,
	input rv32i_types::addr_t mem_address,
	input logic load_pipeline,
	input logic read_data,
	input logic addr_sel,
	input logic load_lru,
	input logic [1:0] load_data,
	input logic [1:0] load_tag,
	input logic [1:0] set_valid,
	input rv32i_types::line_t pmem_rdata,
	output logic hit,
	output logic lru_out,
	output logic [1:0] tag_hit,
	output rv32i_types::word_t mem_rdata,
	output rv32i_types::addr_t pmem_address
);

import rv32i_types::*;

localparam int tag_bits = 32 - idx_bits - offset_bits;

addr_t held_addr;
logic [idx_bits-1:0] held_index;
logic [idx_bits-1:0] read_index;
logic [tag_bits-1:0] held_tag;
logic [word_sel_bits-1:0] held_word;
line_t way0_line;
line_t way1_line;
line_t hit_line;

always_ff @(posedge clk) begin
	if (load_pipeline)
		held_addr <= mem_address;
end

assign held_index = held_addr[offset_bits +: idx_bits];
assign held_tag = held_addr[31 -: tag_bits];
assign held_word = held_addr[offset_bits-1 -: word_sel_bits];

// New request index, or the held one for the re-read after a fill.
assign read_index = addr_sel ? held_index : mem_address[offset_bits +: idx_bits];

assign pmem_address = {held_addr[31:offset_bits], {offset_bits{1'b0}}};

assign hit_line = tag_hit[1] ? way1_line : way0_line;
assign mem_rdata = hit_line[held_word * $bits(word_t) +: $bits(word_t)];

icache_tag_array #(
	.idx_bits(idx_bits)
) tag_array_i (
	.clk(clk),
	.rst_n(rst_n),
	.read_data(read_data),
	.read_index(read_index),
	.write_index(held_index),
	.cmp_tag(held_tag),
	.load_tag(load_tag),
	.set_valid(set_valid),
	.tag_hit(tag_hit),
	.hit(hit)
);

icache_data_array #(
	.idx_bits(idx_bits)
) data_array_i (
	.clk(clk),
	.read_data(read_data),
	.read_index(read_index),
	.write_index(held_index),
	.load_data(load_data),
	.wdata(pmem_rdata),
	.way0_line(way0_line),
	.way1_line(way1_line)
);

icache_lru #(
	.idx_bits(idx_bits)
) lru_i (
	.clk(clk),
	.rst_n(rst_n),
	.index(held_index),
	.load_lru(load_lru),
	.tag_hit(tag_hit),
	.lru_out(lru_out)
);

endmodule : icache_datapath

//--- logic/icache.sv
module icache #(
	parameter int idx_bits = 3
) (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input rv32i_types::addr_t mem_address,
	output logic mem_resp,
	output rv32i_types::word_t mem_rdata,
	output logic pmem_read,
	output rv32i_types::addr_t pmem_address,
	input rv32i_types::line_t pmem_rdata,
	input logic pmem_resp
);

logic load_pipeline;
logic read_data;
logic addr_sel;
logic load_lru;
logic [1:0] load_data;
logic [1:0] load_tag;
logic [1:0] set_valid;
logic hit;
logic lru_out;

icache_control control_i (
	.clk(clk),
	.rst_n(rst_n),
	.mem_read(mem_read),
	.hit(hit),
	.lru_out(lru_out),
	.pmem_resp(pmem_resp),
	.load_pipeline(load_pipeline),
	.read_data(read_data),
	.addr_sel(addr_sel),
	.load_lru(load_lru),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.load_data(load_data),
	.load_tag(load_tag),
	.set_valid(set_valid)
);

icache_datapath #(
	.idx_bits(idx_bits)
) datapath_i (
	.clk(clk),
	.rst_n(rst_n),
	.mem_address(mem_address),
	.load_pipeline(load_pipeline),
	.read_data(read_data),
	.addr_sel(addr_sel),
	.load_lru(load_lru),
	.load_data(load_data),
	.load_tag(load_tag),
	.set_valid(set_valid),
	.pmem_rdata(pmem_rdata),
	.hit(hit),
	.lru_out(lru_out),
	.tag_hit(),
	.mem_rdata(mem_rdata),
	.pmem_address(pmem_address)
);

endmodule : icache

//--- dv/pmem_model.sv
module pmem_model (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input rv32i_types::addr_t pmem_address,
	output logic pmem_resp,
	output rv32i_types::line_t pmem_rdata
);

import rv32i_types::*;

localparam int drive_delay = 1;

logic [15:0] lfsr;
logic busy;
logic resp_next;
logic [2:0] delay;
addr_t line_addr;

// Taps 16, 14, 13, 11.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic line_t line_contents(input addr_t base);
	line_t l;
	for (int k = 0; k < 8; k++)
		l[k*32 +: 32] = (base + 32'(4 * k)) ^ 32'h5a5a_0000;
	return l;
endfunction

initial begin
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	lfsr = 16'd64475;
	busy = 1'b0;
	resp_next = 1'b0;
	delay = 3'd0;
	line_addr = '0;
	forever begin
		@(negedge clk);
		resp_next = 1'b0;
		if (!rst_n) begin
			busy = 1'b0;
		end else if (busy) begin
			if (delay == 3'd0) begin
				busy = 1'b0;
				resp_next = 1'b1;
			end else begin
				delay = delay - 3'd1;
			end
		end else if (pmem_read && !pmem_resp) begin
			busy = 1'b1;
			line_addr = pmem_address;
			for (int b = 0; b < 3; b++) begin
				lfsr = lfsr_next(lfsr);
				delay[b] = lfsr[0];	// Extra wait cycles, 0 to 7.
			end
		end
		@(posedge clk);
		#drive_delay;
		pmem_resp = resp_next;
		if (resp_next)
			pmem_rdata = line_contents(line_addr);
	end
end

endmodule : pmem_model

//--- dv/icache_tb.sv
module icache_tb;

import rv32i_types::*;

localparam int idx_bits = 3;
localparam int num_sets = 2 ** idx_bits;
localparam int tag_bits = 32 - idx_bits - offset_bits;
localparam int resp_timeout = 50;
localparam int drive_delay = 1;

typedef struct packed {
	logic do_reset;
	logic gap;	// Drop mem_read for a cycle before this request.
	logic exp_miss;
	addr_t addr;
} stim_t;

logic clk = 1'b0;
logic rst_n;
logic mem_read;
addr_t mem_address;
logic mem_resp;
word_t mem_rdata;
logic pmem_read;
addr_t pmem_address;
line_t pmem_rdata;
logic pmem_resp;

stim_t stim [$];
logic [tag_bits-1:0] ref_tag [2][num_sets];
logic ref_valid [2][num_sets];
logic ref_lru [num_sets];

int fills = 0;
logic fill_pending;
logic pmem_read_prev;
addr_t fill_addr;

always #10 clk = ~clk;

icache #(
	.idx_bits(idx_bits)
) dut_i (
	.clk(clk),
	.rst_n(rst_n),
	.mem_read(mem_read),
	.mem_address(mem_address),
	.mem_resp(mem_resp),
	.mem_rdata(mem_rdata),
	.pmem_read(pmem_read),
	.pmem_address(pmem_address),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

pmem_model pmem_i (
	.clk(clk),
	.rst_n(rst_n),
	.pmem_read(pmem_read),
	.pmem_address(pmem_address),
	.pmem_resp(pmem_resp),
	.pmem_rdata(pmem_rdata)
);

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("MISMATCH at time %0t: %s: got %h, expected %h", $time, what, actual, expected);
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error.");
	end
endtask

function automatic word_t expected_word(input addr_t a);
	return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
endfunction

function automatic stim_t make_entry(input logic r, input logic g, input logic m, input addr_t a);
	stim_t e;
	e.do_reset = r;
	e.gap = g;
	e.exp_miss = m;
	e.addr = a;
	return e;
endfunction

task automatic clear_model;
	for (int s = 0; s < num_sets; s++) begin
		ref_valid[0][s] = 1'b0;
		ref_valid[1][s] = 1'b0;
		ref_lru[s] = 1'b0;
	end
endtask

// Two-way set with one LRU bit; the victim is the way LRU points to.
task automatic predict_access(input addr_t a, output logic miss);
	logic [idx_bits-1:0] idx;
	logic [tag_bits-1:0] tag;
	int way;
	idx = a[offset_bits +: idx_bits];
	tag = a[31:offset_bits+idx_bits];
	miss = 1'b1;
	way = ref_lru[idx] ? 1 : 0;
	for (int w = 0; w < 2; w++) begin
		if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
			miss = 1'b0;
			way = w;
		end
	end
	if (miss) begin
		ref_tag[way][idx] = tag;
		ref_valid[way][idx] = 1'b1;
	end
	ref_lru[idx] = (way == 0);
endtask

task automatic step_cycle;
	@(posedge clk);
	#drive_delay;
endtask

task automatic apply_reset;
	mem_read = 1'b0;
	rst_n = 1'b0;
	repeat (3)
		step_cycle();
	rst_n = 1'b1;
	clear_model();
endtask

task automatic wait_resp(output int cycles);
	cycles = 0;
	do begin
		step_cycle();
		cycles++;
		if (cycles >= resp_timeout && !mem_resp) begin
			$display("Timeout: no mem_resp within %0d cycles, at time %0t", resp_timeout, $time);
			$display("Result: FAILED");
			$fatal(1, "The cache did not answer a request.");
		end
	end while (!mem_resp);
endtask

// Fill tracking at the falling edge.
always @(negedge clk) begin
	if (!rst_n) begin
		fill_pending = 1'b0;
		pmem_read_prev = 1'b0;
	end else begin
		if (fill_pending)
			check_value({31'b0, mem_resp}, 32'd0, "mem_resp while a fill is pending");
		if (pmem_read && !pmem_read_prev) begin
			fills++;
			fill_addr = pmem_address;
			fill_pending = 1'b1;
		end else if (pmem_read) begin
			check_value(pmem_address, fill_addr, "pmem_address changed during a fill");
		end
		if (pmem_resp)
			fill_pending = 1'b0;
		pmem_read_prev = pmem_read;
	end
end

initial begin
	stim_t entry;
	logic miss;
	int cycles;
	int fills_before;
	rst_n = 1'b0;
	mem_read = 1'b0;
	mem_address = '0;
	stim.push_back(make_entry(1'b0, 1'b1, 1'b1, 32'h0000_1000));	// Cold miss.
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_1004));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_101c));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_1008));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_2000));	// Same set, other way.
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_1010));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_2014));
	stim.push_back(make_entry(1'b0, 1'b1, 1'b0, 32'h0000_100c));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_2018));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_3000));	// Evicts the 0x1000 line.
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_2004));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_1000));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_201c));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_4020));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h8000_00e4));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h1234_5678));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'hffff_fffc));
	stim.push_back(make_entry(1'b0, 1'b1, 1'b0, 32'h8000_00f8));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_4040));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_4024));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h1234_5660));
	stim.push_back(make_entry(1'b1, 1'b0, 1'b0, 32'h0000_0000));	// Second reset.
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_2004));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_2008));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b1, 32'h0000_1000));
	stim.push_back(make_entry(1'b0, 1'b0, 1'b0, 32'h0000_2010));
	apply_reset();
	for (int i = 0; i < stim.size(); i++) begin
		entry = stim[i];
		if (entry.do_reset) begin
			apply_reset();
			repeat (4) begin
				step_cycle();
				check_value({31'b0, mem_resp}, 32'd0, "mem_resp after reset");
				check_value({31'b0, pmem_read}, 32'd0, "pmem_read after reset");
			end
		end else begin
			if (entry.gap && mem_read) begin
				mem_read = 1'b0;
				step_cycle();
				check_value({31'b0, mem_resp}, 32'd0, "mem_resp with no request");
			end
			predict_access(entry.addr, miss);
			check_value({31'b0, miss}, {31'b0, entry.exp_miss}, "table miss column");
			fills_before = fills;
			mem_read = 1'b1;
			mem_address = entry.addr;
			wait_resp(cycles);
			check_value(mem_rdata, expected_word(entry.addr), "mem_rdata");
			check_value(fills - fills_before, miss ? 1 : 0, "number of fills");
			if (miss)
				check_value(fill_addr, entry.addr & ~32'h1f,
					"pmem_address of the fill");
			else
				check_value(cycles, 1, "hit latency in cycles");
		end
	end
	mem_read = 1'b0;
	step_cycle();
	check_value({31'b0, mem_resp}, 32'd0, "mem_resp after the last request");
	$display("Result: PASSED");
	$finish;
end

endmodule : icache_tb

//--- all.f
logic/rv32i_types.sv
logic/icache_control.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_lru.sv
logic/icache_datapath.sv
logic/icache.sv
dv/pmem_model.sv
dv/icache_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module icache_tb -f all.f -o icache_sim \
	&& ./obj_dir/icache_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	|| { echo "Simulation did not pass."; exit 1; }
